// File: hdl/addr_decoder.sv
/*
  Register address decoder.
  Write strobes are single-cycle pulses, only on the cycle-start cycle.
  Read selects are levels held for the whole active bus cycle.
  Unknown offsets decode to nothing; such writes are silently ignored.
*/
`timescale 1ns/10ps

module addr_decoder import sdmac_pkg::*; (
  input  logic [ADDR_W-1:0] addr,
  input  logic              rw,       // 1 = read
  input  logic              active,   // Bus cycle in progress
  input  logic              start,    // First cycle of bus cycle
  output logic              wtc_rd,
  output logic              cntr_rd,
  output logic              istr_rd,
  output logic              cntr_wr,
  output logic              acr_wr,
  output logic              st_dma,
  output logic              sp_dma,
  output logic              flush,
  output logic              clr_int,
  output logic              data_wr
);

  reg_sel_e sel;
  logic     rd_cyc;
  logic     wr_cyc;

  always_comb begin
    case (addr)
      OFF_WTC:     sel = REG_WTC;
      OFF_CNTR:    sel = REG_CNTR;
      OFF_ACR:     sel = REG_ACR;
      OFF_ST_DMA:  sel = REG_ST_DMA;
      OFF_FLUSH:   sel = REG_FLUSH;
      OFF_CLR_INT: sel = REG_CLR_INT;
      OFF_ISTR:    sel = REG_ISTR;
      OFF_SP_DMA:  sel = REG_SP_DMA;
      OFF_DATA:    sel = REG_DATA;
      default:     sel = REG_NONE;
    endcase
  end

  assign rd_cyc = active & rw;   // Level for the whole cycle
  assign wr_cyc = start & ~rw;   // One pulse per cycle

  // Read selects
  assign wtc_rd  = rd_cyc & (sel == REG_WTC);
  assign cntr_rd = rd_cyc & (sel == REG_CNTR);
  assign istr_rd = rd_cyc & (sel == REG_ISTR);

  // Write and action strobes
  assign cntr_wr = wr_cyc & (sel == REG_CNTR);
  assign acr_wr  = wr_cyc & (sel == REG_ACR);
  assign st_dma  = wr_cyc & (sel == REG_ST_DMA);
  assign sp_dma  = wr_cyc & (sel == REG_SP_DMA);
  assign flush   = wr_cyc & (sel == REG_FLUSH);
  assign clr_int = wr_cyc & (sel == REG_CLR_INT);
  assign data_wr = wr_cyc & (sel == REG_DATA);

endmodule

// File: hdl/dma_fifo.sv
/*
  Word FIFO between the register block and the SCSI byte port.
  FIFO_DEPTH must be a power of two.
  First-word-fall-through: pop_data is valid whenever not empty.
  Pushes while full are dropped; pops while empty are ignored.
*/
`timescale 1ns/10ps

module dma_fifo import sdmac_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              CLK,
  input  logic              RST_,
  input  logic              push,
  input  logic [DATA_W-1:0] push_data,
  input  logic              pop,
  output logic [DATA_W-1:0] pop_data,
  output logic              empty,
  output logic              full
);

  localparam int AW = $clog2(FIFO_DEPTH);

  logic [DATA_W-1:0] mem [FIFO_DEPTH];
  logic [AW:0]       wr_ptr;   // Extra bit tells full from empty
  logic [AW:0]       rd_ptr;
  logic              do_push;
  logic              do_pop;

  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) &&
                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

  // Storage
  always_ff @(posedge CLK) begin
    if (do_push)
      mem[wr_ptr[AW-1:0]] <= push_data;
  end

  // Pointers, push and pop may coincide
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign pop_data = mem[rd_ptr[AW-1:0]];   // Head word

endmodule

// File: hdl/registers.sv
/*
  Register block on the CPU side.
  A cycle runs while cs_ and as_ are both low; it is sampled once
  before decode, so writes land one edge after the sample.
  dsack_ falls at the second edge after cycle start.
  Unselected reads return zero. Data-port words go straight to the FIFO.
*/
`timescale 1ns/10ps

module registers import sdmac_pkg::*; (
  input  logic              CLK,
  input  logic              RST_,
  input  logic [ADDR_W-1:0] addr,
  input  logic              cs_,
  input  logic              as_,
  input  logic              rw,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  output logic              dsack_,
  input  logic              fifo_empty,
  input  logic              fifo_full,
  input  logic              stop_flush,
  input  logic              scsi_int,
  output logic              push_word,
  output logic [DATA_W-1:0] push_data,
  output logic              flush_fifo,
  output logic              a1,
  output logic              dma_dir,
  output logic              dma_ena,
  output logic              periph_reset,
  output logic              int_
);

  logic bus_sel, active, active_d, start, ack_arm;
  logic wtc_rd, cntr_rd, istr_rd;
  logic cntr_wr, acr_wr, st_dma, sp_dma, flush, clr_int, data_wr;
  logic int_ena;
  logic [CNTR_W-1:0] cntr_o;
  logic [ISTR_W-1:0] istr_o;
  reg_sel_e rd_sel;

  assign bus_sel = ~cs_ & ~as_;
  assign start   = active & ~active_d;   // Newly set active flag

  // Cycle sampling and DSACK timing
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      active   <= 1'b0;
      active_d <= 1'b0;
      ack_arm  <= 1'b0;
      dsack_   <= 1'b1;
    end else begin
      active   <= bus_sel;
      active_d <= active;
      if (!bus_sel) begin
        ack_arm <= 1'b0;
        dsack_  <= 1'b1;   // Release once strobe is gone
      end else begin
        if (start)   ack_arm <= 1'b1;
        if (ack_arm) dsack_  <= 1'b0;
      end
    end
  end

  addr_decoder u_addr_decoder (
    .addr(addr), .rw(rw), .active(active), .start(start),
    .wtc_rd(wtc_rd), .cntr_rd(cntr_rd), .istr_rd(istr_rd),
    .cntr_wr(cntr_wr), .acr_wr(acr_wr), .st_dma(st_dma), .sp_dma(sp_dma),
    .flush(flush), .clr_int(clr_int), .data_wr(data_wr)
  );

  registers_cntr u_registers_cntr (
    .CLK(CLK), .RST_(RST_), .cntr_wr(cntr_wr), .st_dma(st_dma), .sp_dma(sp_dma),
    .wdata(wdata[CNTR_W-1:0]), .cntr_o(cntr_o), .dma_dir(dma_dir),
    .int_ena(int_ena), .periph_reset(periph_reset), .dma_ena(dma_ena)
  );

  registers_istr u_registers_istr (
    .CLK(CLK), .RST_(RST_), .fifo_empty(fifo_empty), .fifo_full(fifo_full),
    .clr_int(clr_int), .int_ena(int_ena), .scsi_int(scsi_int),
    .istr_o(istr_o), .int_(int_)
  );

  // Flush flag, set wins over clear
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      flush_fifo <= 1'b0;
    else if (flush)
      flush_fifo <= 1'b1;
    else if (stop_flush)
      flush_fifo <= 1'b0;
  end

  // A1 from ACR writes
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      a1 <= 1'b0;
    else if (acr_wr)
      a1 <= wdata[25];
  end

  // Read mux
  always_comb begin
    rd_sel = REG_NONE;
    if (wtc_rd)       rd_sel = REG_WTC;
    else if (cntr_rd) rd_sel = REG_CNTR;
    else if (istr_rd) rd_sel = REG_ISTR;
    case (rd_sel)
      REG_WTC:  rdata = DATA_W'(4);   // No real counter
      REG_CNTR: rdata = DATA_W'(cntr_o);
      REG_ISTR: rdata = DATA_W'(istr_o);
      default:  rdata = '0;
    endcase
  end

  assign push_word = data_wr;
  assign push_data = wdata;

endmodule

// File: hdl/registers_cntr.sv
/*
  Control register.
  Only DMADIR, INTENA and PRESET are writable; other bits read as zero.
  DMAENA is set by the start strobe and cleared by the stop strobe,
  stop wins when both arrive together.
*/
`timescale 1ns/10ps

module registers_cntr import sdmac_pkg::*; (
  input  logic              CLK,
  input  logic              RST_,
  input  logic              cntr_wr,
  input  logic              st_dma,
  input  logic              sp_dma,
  input  logic [CNTR_W-1:0] wdata,
  output logic [CNTR_W-1:0] cntr_o,
  output logic              dma_dir,
  output logic              int_ena,
  output logic              periph_reset,
  output logic              dma_ena
);

  // Writable bits
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      dma_dir      <= 1'b0;
      int_ena      <= 1'b0;
      periph_reset <= 1'b0;
    end else if (cntr_wr) begin
      dma_dir      <= wdata[CNTR_DMADIR];
      int_ena      <= wdata[CNTR_INTENA];
      periph_reset <= wdata[CNTR_PRESET];
    end
  end

  // DMA enable, strobe driven
  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      dma_ena <= 1'b0;
    else if (sp_dma)
      dma_ena <= 1'b0;   // Stop has priority
    else if (st_dma)
      dma_ena <= 1'b1;
  end

  always_comb begin
    cntr_o              = '0;
    cntr_o[CNTR_DMADIR] = dma_dir;
    cntr_o[CNTR_INTENA] = int_ena;
    cntr_o[CNTR_PRESET] = periph_reset;
    cntr_o[CNTR_DMAENA] = dma_ena;
  end

endmodule

// File: hdl/registers_istr.sv
/*
  Interrupt status register.
  Pending is set by any cycle with scsi_int high, so a held
  interrupt cannot be cleared until the source drops.
  int_ is active low and only asserts with INTENA set.
*/
`timescale 1ns/10ps

module registers_istr import sdmac_pkg::*; (
  input  logic              CLK,
  input  logic              RST_,
  input  logic              fifo_empty,
  input  logic              fifo_full,
  input  logic              clr_int,
  input  logic              int_ena,
  input  logic              scsi_int,   // Live SCSI chip interrupt
  output logic [ISTR_W-1:0] istr_o,
  output logic              int_
);

  logic int_p;   // Interrupt pending

  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_)
      int_p <= 1'b0;
    else if (scsi_int)
      int_p <= 1'b1;     // Source still high beats clear
    else if (clr_int)
      int_p <= 1'b0;
  end

  assign int_ = ~(int_p & int_ena);

  // Status word, unused bits read zero
  always_comb begin
    istr_o             = '0;
    istr_o[ISTR_FE]    = fifo_empty;
    istr_o[ISTR_FF]    = fifo_full;
    istr_o[ISTR_INT_P] = int_p;
    istr_o[ISTR_INTS]  = scsi_int;
    istr_o[ISTR_INT_F] = ~int_;   // Output currently asserted
  end

endmodule

// File: hdl/scsi_byte_port.sv
/*
  SCSI-side byte port, memory-to-device only.
  Bytes leave most significant first, one per cycle with scsi_rdy high,
  and only while running (DMA on toward device, or flushing).
  A new word is taken only once all bytes of the current one are out.
*/
`timescale 1ns/10ps

module scsi_byte_port import sdmac_pkg::*; (
  input  logic              CLK,
  input  logic              RST_,
  input  logic              dma_ena,
  input  logic              dma_dir,
  input  logic              flush_fifo,
  input  logic              fifo_empty,
  output logic              pop,
  input  logic [DATA_W-1:0] pop_data,
  input  logic              scsi_rdy,
  output logic              scsi_stb,
  output logic [7:0]        scsi_data,
  output logic              stop_flush
);

  localparam int BYTES = DATA_W / 8;
  localparam int CW    = $clog2(BYTES) + 1;

  logic [DATA_W-1:0] shreg;   // Word being sent
  logic [CW-1:0]     cnt;     // Bytes left in shreg
  logic              running;
  logic              held;

  assign running = (dma_ena & dma_dir) | flush_fifo;
  assign held    = (cnt != '0);

  assign pop        = running & ~held & ~fifo_empty;
  assign scsi_stb   = running & held & scsi_rdy;
  assign scsi_data  = shreg[DATA_W-1 -: 8];      // MSB first
  assign stop_flush = fifo_empty & ~held;        // Nothing left anywhere

  always_ff @(posedge CLK or negedge RST_) begin
    if (!RST_) begin
      shreg <= '0;
      cnt   <= '0;
    end else if (pop) begin
      shreg <= pop_data;
      cnt   <= CW'(BYTES);
    end else if (scsi_stb) begin
      shreg <= shreg << 8;
      cnt   <= cnt - 1'b1;
    end
  end

endmodule

// File: hdl/sdmac_core.sv
/*
  Top level of the SCSI DMA host core.
  Connects register block, word FIFO and SCSI byte port.
  FIFO_DEPTH must be a power of two; it sizes the data FIFO.
*/
`timescale 1ns/10ps

module sdmac_core import sdmac_pkg::*; #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic              CLK,
  input  logic              RST_,
  input  logic [ADDR_W-1:0] addr,
  input  logic              cs_,
  input  logic              as_,
  input  logic              rw,
  input  logic [DATA_W-1:0] wdata,
  output logic [DATA_W-1:0] rdata,
  output logic              dsack_,
  input  logic              scsi_int,
  input  logic              scsi_rdy,
  output logic              scsi_stb,
  output logic [7:0]        scsi_data,
  output logic              int_,
  output logic              dma_dir,
  output logic              dma_ena,
  output logic              periph_reset,
  output logic              a1
);

  logic              fifo_empty, fifo_full, stop_flush, flush_fifo;
  logic              push_word, pop;
  logic [DATA_W-1:0] push_data, pop_data;

  registers u_registers (
    .CLK(CLK), .RST_(RST_), .addr(addr), .cs_(cs_), .as_(as_), .rw(rw),
    .wdata(wdata), .rdata(rdata), .dsack_(dsack_),
    .fifo_empty(fifo_empty), .fifo_full(fifo_full), .stop_flush(stop_flush),
    .scsi_int(scsi_int), .push_word(push_word), .push_data(push_data),
    .flush_fifo(flush_fifo), .a1(a1), .dma_dir(dma_dir), .dma_ena(dma_ena),
    .periph_reset(periph_reset), .int_(int_)
  );

  dma_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_dma_fifo (
    .CLK(CLK), .RST_(RST_), .push(push_word), .push_data(push_data),
    .pop(pop), .pop_data(pop_data), .empty(fifo_empty), .full(fifo_full)
  );

  scsi_byte_port u_scsi_byte_port (
    .CLK(CLK), .RST_(RST_), .dma_ena(dma_ena), .dma_dir(dma_dir),
    .flush_fifo(flush_fifo), .fifo_empty(fifo_empty), .pop(pop),
    .pop_data(pop_data), .scsi_rdy(scsi_rdy), .scsi_stb(scsi_stb),
    .scsi_data(scsi_data), .stop_flush(stop_flush)
  );

endmodule

// File: hdl/sdmac_pkg.sv
/*
  Shared definitions for the SCSI DMA host core.
  Register offsets are byte addresses on an 8-bit CPU address bus.
  Only the memory-to-device data direction is modelled.
  WTC always reads back the constant 4; no transfer counter exists.
*/
package sdmac_pkg;

  localparam int DATA_W = 32;   // CPU data bus
  localparam int ADDR_W = 8;    // CPU address bus
  localparam int CNTR_W = 9;    // Control register
  localparam int ISTR_W = 9;    // Interrupt status register

  // Register offsets
  localparam logic [ADDR_W-1:0] OFF_WTC     = 8'h00;
  localparam logic [ADDR_W-1:0] OFF_CNTR    = 8'h08;
  localparam logic [ADDR_W-1:0] OFF_ACR     = 8'h0C;
  localparam logic [ADDR_W-1:0] OFF_ST_DMA  = 8'h10;
  localparam logic [ADDR_W-1:0] OFF_FLUSH   = 8'h14;
  localparam logic [ADDR_W-1:0] OFF_CLR_INT = 8'h18;
  localparam logic [ADDR_W-1:0] OFF_ISTR    = 8'h1C;
  localparam logic [ADDR_W-1:0] OFF_SP_DMA  = 8'h3C;
  localparam logic [ADDR_W-1:0] OFF_DATA    = 8'h40;

  typedef enum logic [3:0] {
    REG_NONE, REG_WTC, REG_CNTR, REG_ACR, REG_ST_DMA,
    REG_FLUSH, REG_CLR_INT, REG_ISTR, REG_SP_DMA, REG_DATA
  } reg_sel_e;

  // Control register bits
  localparam int CNTR_DMADIR = 1;   // 1 = toward the device
  localparam int CNTR_INTENA = 2;
  localparam int CNTR_PRESET = 4;
  localparam int CNTR_DMAENA = 8;   // Strobe controlled, read only

  // Status register bits
  localparam int ISTR_FE    = 0;
  localparam int ISTR_FF    = 1;
  localparam int ISTR_INT_P = 4;
  localparam int ISTR_INTS  = 5;
  localparam int ISTR_INT_F = 8;

endpackage

// File: list.f
hdl/sdmac_pkg.sv
hdl/addr_decoder.sv
hdl/registers_cntr.sv
hdl/registers_istr.sv
hdl/registers.sv
hdl/dma_fifo.sv
hdl/scsi_byte_port.sv
hdl/sdmac_core.sv
testbench/sdmac_core_props.sv
testbench/sdmac_core_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SCSI DMA core testbench with Verilator.
# Exit status is 0 only when the log holds no failure and a pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --assert --timescale 1ns/10ps --top-module sdmac_core_tb \
  -f list.f || exit 1
./obj_dir/Vsdmac_core_tb +verilator+error+limit+100 > sim.log 2>&1 \
  || echo "simulator exited with an error status" >> sim.log
cat sim.log
! grep -q "Test failed" sim.log && grep -q "Test passed" sim.log \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }

// File: testbench/sdmac_core_props.sv
/*
  Bound checks on the SCSI DMA core top level.
  dsack_ may trail the end of a bus cycle by one clock.
  int_ena and the byte-held flag are taken from inside the core.
*/
`timescale 1ns/10ps

module sdmac_core_props (
  input logic       CLK,
  input logic       RST_,
  input logic       cs_,
  input logic       as_,
  input logic       dsack_,
  input logic       scsi_rdy,
  input logic       scsi_stb,
  input logic [7:0] scsi_data,
  input logic       held,       // Byte port holds a byte
  input logic       scsi_int,
  input logic       int_,
  input logic       int_ena
);

  int unsigned fail_cnt = 0;   // Failed assertion count

  // Termination only inside a cycle plus one clock of release
  dsack_in_cycle: assert property (@(posedge CLK) disable iff (!RST_)
    !dsack_ |-> (!$past(cs_) && !$past(as_)))
  else begin
    fail_cnt++;
    $error("dsack_ low outside a bus cycle");
  end

  // Byte held back by low scsi_rdy stays put and is not strobed
  stb_needs_rdy: assert property (@(posedge CLK) disable iff (!RST_)
    held && !scsi_rdy |=> held && $stable(scsi_data) && !$past(scsi_stb))
  else begin
    fail_cnt++;
    $error("SCSI byte moved while scsi_rdy low");
  end

  // int_ low needs INTENA, and it falls only after a SCSI interrupt or enable
  int_needs_ena: assert property (@(posedge CLK) disable iff (!RST_)
    !int_ |-> int_ena && (!$past(int_) || $past(scsi_int) || $rose(int_ena)))
  else begin
    fail_cnt++;
    $error("int_ low without INTENA or without a SCSI interrupt");
  end

endmodule

bind sdmac_core sdmac_core_props props0 (
  .CLK(CLK), .RST_(RST_), .cs_(cs_), .as_(as_), .dsack_(dsack_),
  .scsi_rdy(scsi_rdy), .scsi_stb(scsi_stb), .scsi_data(scsi_data),
  .held(u_scsi_byte_port.held), .scsi_int(scsi_int), .int_(int_),
  .int_ena(u_registers.int_ena)
);

// File: testbench/sdmac_core_tb.sv
/*
  Testbench for the SCSI DMA host core.
  Steps are built into a table at time zero and run in order.
  FIFO_DEPTH is read from the DUT; the data-flow steps assume 8 or more.
  SCSI bytes are scored against a byte queue filled on accepted writes.
  Outputs are sampled on the falling edge, inputs driven on the rising one.
*/
`timescale 1ns/10ps

module sdmac_core_tb;

  localparam logic [31:0] SEED = 32'h722c3916;

  // Register offsets
  localparam logic [7:0] A_WTC     = 8'h00;
  localparam logic [7:0] A_NONE    = 8'h04;   // Unmapped
  localparam logic [7:0] A_CNTR    = 8'h08;
  localparam logic [7:0] A_ACR     = 8'h0C;
  localparam logic [7:0] A_ST_DMA  = 8'h10;
  localparam logic [7:0] A_FLUSH   = 8'h14;
  localparam logic [7:0] A_CLR_INT = 8'h18;
  localparam logic [7:0] A_ISTR    = 8'h1C;
  localparam logic [7:0] A_SP_DMA  = 8'h3C;
  localparam logic [7:0] A_DATA    = 8'h40;

  typedef enum logic [2:0] {OP_WR, OP_RD, OP_WFLUSH, OP_SINT, OP_PINS} op_e;
  typedef enum logic [1:0] {RDY_LO, RDY_HI, RDY_RAND} rdy_e;
  typedef struct packed {
    op_e         op;
    logic [7:0]  addr;
    logic [31:0] wdata;   // SINT level in bit 0
    logic [31:0] exp;     // Read data or pin vector
    rdy_e        rdy;
  } step_t;

  logic        CLK;
  logic        RST_;
  logic [7:0]  addr;
  logic        cs_;
  logic        as_;
  logic        rw;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        dsack_;
  logic        scsi_int;
  logic        scsi_rdy;
  logic        scsi_stb;
  logic [7:0]  scsi_data;
  logic        int_;
  logic        dma_dir;
  logic        dma_ena;
  logic        periph_reset;
  logic        a1;

  step_t       steps[$];
  logic [7:0]  ref_q[$];          // Expected bytes, oldest first
  rdy_e        rdy_mode = RDY_LO;
  int          errors = 0;
  int          depth;
  logic        table_ready = 1'b0;

  sdmac_core dut0 (.*);

  initial CLK = 1'b0;
  always #10 CLK = ~CLK;   // 20 ns period

  task automatic add_step(input op_e op, input logic [7:0] a, input logic [31:0] d,
                          input logic [31:0] e, input rdy_e m);
    step_t s;
    s.op    = op;
    s.addr  = a;
    s.wdata = d;
    s.exp   = e;
    s.rdy   = m;
    steps.push_back(s);
  endtask

  // Pin vector is {a1, periph_reset, dma_ena, dma_dir, int_}
  task automatic build_table();
    add_step(OP_RD, A_CNTR, 32'h0, 32'h000, RDY_LO);   // Reset values
    add_step(OP_RD, A_ISTR, 32'h0, 32'h001, RDY_LO);
    add_step(OP_RD, A_WTC, 32'h0, 32'h004, RDY_LO);
    add_step(OP_RD, A_NONE, 32'h0, 32'h000, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h01, RDY_LO);
    add_step(OP_WR, A_CNTR, 32'h016, 32'h0, RDY_LO);   // DIR, INTENA, PRESET
    add_step(OP_RD, A_CNTR, 32'h0, 32'h016, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h0B, RDY_LO);
    add_step(OP_WR, A_CNTR, 32'h1FF, 32'h0, RDY_LO);   // Only writable bits stick
    add_step(OP_RD, A_CNTR, 32'h0, 32'h016, RDY_LO);
    add_step(OP_WR, A_CNTR, 32'h006, 32'h0, RDY_LO);
    add_step(OP_RD, A_CNTR, 32'h0, 32'h006, RDY_LO);
    add_step(OP_WR, A_ST_DMA, 32'h0, 32'h0, RDY_LO);
    add_step(OP_RD, A_CNTR, 32'h0, 32'h106, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h07, RDY_LO);
    add_step(OP_WR, A_SP_DMA, 32'h0, 32'h0, RDY_LO);
    add_step(OP_RD, A_CNTR, 32'h0, 32'h006, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h03, RDY_LO);
    add_step(OP_WR, A_ST_DMA, 32'h0, 32'h0, RDY_RAND);   // Data flow toward device
    for (int i = 0; i < 5; i++)
      add_step(OP_WR, A_DATA, 32'h1020_3040 + 32'(i) * 32'h0101_0101, 32'h0, RDY_RAND);
    add_step(OP_WR, A_FLUSH, 32'h0, 32'h0, RDY_RAND);
    add_step(OP_WFLUSH, A_NONE, 32'h0, 32'h0, RDY_RAND);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h001, RDY_RAND);
    add_step(OP_WR, A_SP_DMA, 32'h0, 32'h0, RDY_RAND);
    for (int i = 0; i < depth + 2; i++)   // Overfill, port stopped
      add_step(OP_WR, A_DATA, 32'hC0DE_0000 + 32'(i), 32'h0, RDY_RAND);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h002, RDY_RAND);
    add_step(OP_WR, A_FLUSH, 32'h0, 32'h0, RDY_RAND);
    add_step(OP_WFLUSH, A_NONE, 32'h0, 32'h0, RDY_RAND);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h001, RDY_RAND);
    add_step(OP_WR, A_CNTR, 32'h002, 32'h0, RDY_LO);   // Interrupts, INTENA off
    add_step(OP_SINT, A_NONE, 32'h1, 32'h0, RDY_LO);
    add_step(OP_SINT, A_NONE, 32'h0, 32'h0, RDY_LO);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h011, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h03, RDY_LO);
    add_step(OP_WR, A_CNTR, 32'h006, 32'h0, RDY_LO);   // INTENA on
    add_step(OP_RD, A_ISTR, 32'h0, 32'h111, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h02, RDY_LO);
    add_step(OP_WR, A_CLR_INT, 32'h0, 32'h0, RDY_LO);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h001, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h03, RDY_LO);
    add_step(OP_SINT, A_NONE, 32'h1, 32'h0, RDY_LO);   // Held source beats clear
    add_step(OP_WR, A_CLR_INT, 32'h0, 32'h0, RDY_LO);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h131, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h02, RDY_LO);
    add_step(OP_SINT, A_NONE, 32'h0, 32'h0, RDY_LO);
    add_step(OP_WR, A_CLR_INT, 32'h0, 32'h0, RDY_LO);
    add_step(OP_RD, A_ISTR, 32'h0, 32'h001, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h03, RDY_LO);
    add_step(OP_WR, A_ACR, 32'h0200_0000, 32'h0, RDY_LO);   // A1 from bit 25
    add_step(OP_PINS, A_NONE, 32'h0, 32'h13, RDY_LO);
    add_step(OP_WR, A_ACR, 32'hFDFF_FFFF, 32'h0, RDY_LO);
    add_step(OP_PINS, A_NONE, 32'h0, 32'h03, RDY_LO);
  endtask

  // Word accepted only while the model holds fewer than depth words
  task automatic model_push(input logic [31:0] w);
    if ((ref_q.size() + 3) / 4 < depth) begin
      ref_q.push_back(w[31:24]);   // MSB leaves first
      ref_q.push_back(w[23:16]);
      ref_q.push_back(w[15:8]);
      ref_q.push_back(w[7:0]);
    end
  endtask

  task automatic bus_cycle(input logic [7:0] a, input logic r, input logic [31:0] d,
                           output logic [31:0] q);
    int n;
    @(posedge CLK);
    addr  <= a;
    rw    <= r;
    wdata <= d;
    cs_   <= 1'b0;
    as_   <= 1'b0;
    n = 0;
    do begin
      @(negedge CLK);
      n++;
    end while (dsack_ && n < 16);   // Wait for termination
    q = rdata;
    if (dsack_) begin
      errors++;
      $display("dsack_ never fell for the bus cycle at offset %h", a);
    end
    @(posedge CLK);
    cs_ <= 1'b1;
    as_ <= 1'b1;
    rw  <= 1'b1;
    @(posedge CLK);   // Idle clock between cycles
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] got;
    logic [4:0]  pins;
    int          n;
    rdy_mode <= s.rdy;
    case (s.op)
      OP_WR: begin
        if (s.addr == A_DATA)
          model_push(s.wdata);
        bus_cycle(s.addr, 1'b0, s.wdata, got);
      end
      OP_RD: begin
        bus_cycle(s.addr, 1'b1, 32'h0, got);
        if (got !== s.exp) begin
          errors++;
          $display("error: rdata at offset %h exp %h got %h", s.addr, s.exp, got);
        end
      end
      OP_WFLUSH: begin
        n = 0;
        do begin
          @(negedge CLK);
          n++;
        end while (dut0.flush_fifo && n < 1024);
        if (dut0.flush_fifo) begin
          errors++;
          $display("flush still running after %0d cycles", n);
        end
        @(posedge CLK);
      end
      OP_SINT: begin
        @(posedge CLK);
        scsi_int <= s.wdata[0];
        @(posedge CLK);
      end
      default: begin   // Pin check
        @(negedge CLK);
        pins = {a1, periph_reset, dma_ena, dma_dir, int_};
        if (pins !== s.exp[4:0]) begin
          errors++;
          $display("error: {a1,periph_reset,dma_ena,dma_dir,int_} exp %h got %h",
                   s.exp[4:0], pins);
        end
        @(posedge CLK);
      end
    endcase
  endtask

  // SCSI ready level
  initial begin
    logic [31:0] r;
    void'($urandom(SEED));
    scsi_rdy <= 1'b0;
    forever begin
      @(posedge CLK);
      r = $urandom();
      case (rdy_mode)
        RDY_HI:   scsi_rdy <= 1'b1;
        RDY_RAND: scsi_rdy <= r[0];
        default:  scsi_rdy <= 1'b0;
      endcase
    end
  end

  // Byte monitor
  always @(negedge CLK) begin
    if (RST_ && scsi_stb) begin
      if (ref_q.size() == 0) begin
        errors++;
        $display("SCSI byte %h sent while no byte was expected", scsi_data);
      end else begin
        if (scsi_data !== ref_q[0]) begin
          errors++;
          $display("error: scsi_data exp %h got %h", ref_q[0], scsi_data);
        end
        void'(ref_q.pop_front());
      end
    end
  end

  // Watchdog sized from the table
  initial begin
    wait (table_ready);
    repeat (steps.size() * 64) @(posedge CLK);
    $display("timeout, steps not finished after %0d cycles", steps.size() * 64);
    $display("closing: %0d errors, %0d assertion failures", errors, dut0.props0.fail_cnt);
    $display("Test failed");
    $finish;
  end

  initial begin
    RST_     <= 1'b0;
    cs_      <= 1'b1;
    as_      <= 1'b1;
    rw       <= 1'b1;
    addr     <= 8'h00;
    wdata    <= 32'h0;
    scsi_int <= 1'b0;
    depth = dut0.FIFO_DEPTH;
    build_table();
    table_ready = 1'b1;
    repeat (8) @(posedge CLK);   // Reset for 8 clocks
    RST_ <= 1'b1;
    repeat (2) @(posedge CLK);
    foreach (steps[i])
      run_step(steps[i]);
    repeat (8) @(posedge CLK);
    if (ref_q.size() != 0) begin
      errors++;
      $display("%0d expected SCSI bytes never left the core", ref_q.size());
    end
    $display("closing: %0d errors, %0d assertion failures", errors, dut0.props0.fail_cnt);
    if (errors == 0 && dut0.props0.fail_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule
